// ==== logic/quiz_pkg.sv ====
package quiz_pkg;

    ////////////////////////////////////////////////////////////////////////
    // question categories
    ////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        CAT_CONVERT = 3'd1,     // binary to octal, decimal or hex digits
        CAT_SIGNED  = 3'd2,     // signed add and subtract
        CAT_SHIFT   = 3'd3,
        CAT_BITWISE = 3'd4,
        CAT_LOGIC   = 3'd5      // operators on truth values
    } quiz_category_e;          // 0, 6 and 7 never match

    ////////////////////////////////////////////////////////////////////////
    // field widths
    ////////////////////////////////////////////////////////////////////////

    localparam int QUESTION_INDEX_WIDTH = 6;   // up to 63 questions
    localparam int PLAYER_INDEX_WIDTH   = 2;   // up to 4 players
    localparam int OPERAND_WIDTH        = 8;
    localparam int ANSWER_WIDTH         = 3 * OPERAND_WIDTH;
    localparam int SECONDS_WIDTH        = 5;

    typedef logic [OPERAND_WIDTH-1:0]        operand_t;   // operands and keyed bytes
    typedef logic [1:0]                      op_sel_t;
    typedef logic [ANSWER_WIDTH-1:0]         answer_t;    // first byte in 23..16
    typedef logic [SECONDS_WIDTH-1:0]        seconds_t;
    typedef logic [QUESTION_INDEX_WIDTH-1:0] question_index_t;
    typedef logic [PLAYER_INDEX_WIDTH-1:0]   player_index_t;

endpackage

// ==== logic/second_tick.sv ====
`timescale 1ns/100ps

module second_tick #(
    parameter int TICKS_PER_SECOND = 10
) (
    input  logic clk,
    input  logic reset,
    input  logic tick_restart,
    output logic tick
);

    localparam int COUNT_WIDTH = (TICKS_PER_SECOND > 1) ? $clog2(TICKS_PER_SECOND) : 1;
    localparam logic [COUNT_WIDTH-1:0] COUNT_LAST = COUNT_WIDTH'(TICKS_PER_SECOND - 1);

    logic [COUNT_WIDTH-1:0] count;

    always_ff @(posedge clk) begin
        if (reset || tick_restart) begin
            count <= '0;                                // realign to question start
            tick  <= 1'b0;
        end else if (count == COUNT_LAST) begin
            count <= '0;
            tick  <= 1'b1;                              // one cycle per wrap
        end else begin
            count <= count + COUNT_WIDTH'(1);
            tick  <= 1'b0;
        end
    end

endmodule

// ==== logic/answer_entry.sv ====
`timescale 1ns/100ps

module answer_entry import quiz_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           entry_enable,
    input  logic           entry_clear,
    input  quiz_category_e question_category,
    input  operand_t       answer_byte,
    input  logic           enter_byte,
    input  logic           confirm,
    output answer_t        answer_value,
    output logic           answer_complete
);

    typedef enum logic [1:0] {
        ENTRY_FIRST,
        ENTRY_SECOND,
        ENTRY_LAST
    } entry_state_e;

    entry_state_e entry_state;
    operand_t     first_byte;
    operand_t     second_byte;
    logic         multi_byte;
    logic         take_first;
    logic         take_second;

    // conversion and signed answers are three digits
    assign multi_byte = (question_category == CAT_CONVERT) ||
                        (question_category == CAT_SIGNED);

    assign take_first  = entry_enable && multi_byte && enter_byte &&
                         (entry_state == ENTRY_FIRST);
    assign take_second = entry_enable && multi_byte && enter_byte &&
                         (entry_state == ENTRY_SECOND);

    // early confirm on a three-byte answer is dropped
    assign answer_complete = entry_enable && confirm &&
                             (!multi_byte || (entry_state == ENTRY_LAST));

    // last byte comes straight from the keys on the confirm cycle
    assign answer_value = multi_byte ? {first_byte, second_byte, answer_byte}
                                     : {answer_byte, 16'h0000};

    always_ff @(posedge clk) begin
        if (reset || entry_clear) begin
            entry_state <= ENTRY_FIRST;
        end else begin
            case (entry_state)
                ENTRY_FIRST: begin
                    if (take_first) begin
                        entry_state <= ENTRY_SECOND;
                    end
                end
                ENTRY_SECOND: begin
                    if (take_second) begin
                        entry_state <= ENTRY_LAST;
                    end
                end
                ENTRY_LAST: begin
                    if (answer_complete) begin
                        entry_state <= ENTRY_FIRST;        // ready for next question
                    end
                end
                default: entry_state <= ENTRY_FIRST;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_first) begin
            first_byte <= answer_byte;                    // hundreds digit / sign
        end
        if (take_second) begin
            second_byte <= answer_byte;
        end
    end

endmodule

// ==== logic/answer_checker.sv ====
`timescale 1ns/100ps

module answer_checker import quiz_pkg::*; (
    input  quiz_category_e question_category,
    input  op_sel_t        question_op,
    input  operand_t       question_a,
    input  operand_t       question_b,
    input  answer_t        answer_value,
    output logic           answer_correct
);

    // hundreds, tens and ones in the low nibble of each byte
    function automatic answer_t decimal_digits(input operand_t value);
        operand_t hundreds;
        operand_t tens;
        operand_t ones;
        hundreds = value / 8'd100;
        tens     = (value / 8'd10) % 8'd10;
        ones     = value % 8'd10;
        return {4'h0, hundreds[3:0], 4'h0, tens[3:0], 4'h0, ones[3:0]};
    endfunction

    answer_t    convert_result;
    answer_t    expected;
    operand_t   signed_result;
    operand_t   magnitude;
    operand_t   shift_result;
    operand_t   bitwise_result;
    logic [2:0] shift_amount;
    logic       a_true;
    logic       b_true;
    logic       logic_result;
    logic       category_valid;

    assign shift_amount = question_b[2:0];          // only 0..7 positions
    assign a_true       = |question_a;
    assign b_true       = |question_b;

    ////////////////////////////////////////////////////////////////////////////
    // per-category results
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (question_op)
            2'd0: convert_result = {6'h00, question_a[7:6], 5'h00, question_a[5:3],
                                    5'h00, question_a[2:0]};         // octal
            2'd1: convert_result = decimal_digits(question_a);
            2'd2: convert_result = {8'h00, 4'h0, question_a[7:4], 4'h0, question_a[3:0]};
            default: convert_result = '0;
        endcase
    end

    always_comb begin
        case (question_op)
            2'd0: signed_result = question_a + question_b;   // wraps to 8 bits
            2'd1: signed_result = question_a - question_b;
            default: signed_result = '0;
        endcase
        magnitude = signed_result[7] ? operand_t'(-signed_result) : signed_result;
    end

    always_comb begin
        case (question_op)
            2'd0, 2'd2: shift_result = question_a << shift_amount;   // both left shifts
            2'd1: shift_result = operand_t'($signed(question_a) >>> shift_amount);
            default: shift_result = question_a >> shift_amount;
        endcase
    end

    always_comb begin
        case (question_op)
            2'd0: begin
                bitwise_result = question_a & question_b;
                logic_result   = a_true && b_true;
            end
            2'd1: begin
                bitwise_result = question_a | question_b;
                logic_result   = a_true || b_true;
            end
            2'd2: begin
                bitwise_result = ~question_a;
                logic_result   = !a_true;
            end
            default: begin
                bitwise_result = question_a ^ question_b;
                logic_result   = a_true ^ b_true;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // select and compare
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        category_valid = 1'b1;
        case (question_category)
            CAT_CONVERT: expected = convert_result;
            CAT_SIGNED:  expected = decimal_digits(magnitude) |
                                    {signed_result[7], 23'h000000};  // sign flag in bit 23
            CAT_SHIFT:   expected = {shift_result, 16'h0000};
            CAT_BITWISE: expected = {bitwise_result, 16'h0000};
            CAT_LOGIC:   expected = {{8{logic_result}}, 16'h0000};
            default: begin
                expected       = '0;
                category_valid = 1'b0;                  // bad category never scores
            end
        endcase
    end

    assign answer_correct = category_valid && (expected == answer_value);

endmodule

// ==== logic/round_control.sv ====
`timescale 1ns/100ps

module round_control import quiz_pkg::*; #(
    parameter int TIME_LIMIT = 20
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  question_index_t total_questions,
    input  player_index_t   total_players,
    input  logic            tick,
    input  logic            answer_complete,
    input  logic            answer_correct,
    input  answer_t         answer_value,
    input  logic            result_ack,
    output logic            tick_restart,
    output logic            entry_enable,
    output logic            entry_clear,
    output question_index_t question_index,
    output player_index_t   player_index,
    output logic            result_req,
    output player_index_t   result_player,
    output question_index_t result_question,
    output answer_t         result_answer,
    output seconds_t        result_seconds,
    output logic            result_timed_out,
    output logic            result_correct,
    output logic            busy,
    output logic            done
);

    typedef enum logic [2:0] {
        ROUND_IDLE,
        ROUND_ASK,
        ROUND_REPORT,       // req high
        ROUND_RELEASE,      // waiting for ack low
        ROUND_DONE
    } round_state_e;

    localparam seconds_t LIMIT = seconds_t'(TIME_LIMIT);

    round_state_e    state;
    seconds_t        remaining;
    question_index_t last_question;
    player_index_t   last_player;
    logic            begin_round;
    logic            advance;
    logic            round_over;
    logic            time_up;
    logic            capture;

    assign begin_round = start && ((state == ROUND_IDLE) || (state == ROUND_DONE));
    assign advance     = (state == ROUND_RELEASE) && !result_ack;
    assign round_over  = (question_index == last_question) && (player_index == last_player);
    assign time_up     = (state == ROUND_ASK) && tick && (remaining == seconds_t'(1));
    assign capture     = (state == ROUND_ASK) && (answer_complete || time_up);

    assign tick_restart = begin_round || (advance && !round_over);  // new question starts
    assign entry_clear  = tick_restart || time_up;
    assign entry_enable = (state == ROUND_ASK);
    assign busy         = (state == ROUND_ASK) || (state == ROUND_REPORT) ||
                          (state == ROUND_RELEASE);
    assign done         = (state == ROUND_DONE);

    ////////////////////////////////////////////////////////////////////////////
    // round sequencing and handshake
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= ROUND_IDLE;
            remaining      <= LIMIT;
            question_index <= '0;
            player_index   <= '0;
            result_req     <= 1'b0;
        end else begin
            case (state)
                ROUND_IDLE, ROUND_DONE: begin
                    if (start) begin
                        state          <= ROUND_ASK;
                        remaining      <= LIMIT;
                        question_index <= '0;
                        player_index   <= '0;
                    end
                end
                ROUND_ASK: begin
                    if (capture) begin
                        state      <= ROUND_REPORT;
                        result_req <= 1'b1;
                    end else if (tick) begin
                        remaining <= remaining - seconds_t'(1);
                    end
                end
                ROUND_REPORT: begin
                    if (result_ack) begin
                        state      <= ROUND_RELEASE;
                        result_req <= 1'b0;
                    end
                end
                ROUND_RELEASE: begin
                    if (!result_ack) begin
                        remaining <= LIMIT;
                        if (round_over) begin
                            state <= ROUND_DONE;
                        end else if (question_index == last_question) begin
                            state          <= ROUND_ASK;
                            question_index <= '0;                   // next player
                            player_index   <= player_index + player_index_t'(1);
                        end else begin
                            state          <= ROUND_ASK;
                            question_index <= question_index + question_index_t'(1);
                        end
                    end
                end
                default: state <= ROUND_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // round limits and result record
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (begin_round) begin
            last_question <= total_questions - question_index_t'(1);  // 0 wraps to max
            last_player   <= total_players - player_index_t'(1);
        end
        if (capture) begin
            result_player   <= player_index;
            result_question <= question_index;
            if (answer_complete) begin
                result_answer    <= answer_value;
                result_seconds   <= LIMIT - remaining;            // whole seconds used
                result_timed_out <= 1'b0;
                result_correct   <= answer_correct;
            end else begin
                result_answer    <= '0;
                result_seconds   <= LIMIT;
                result_timed_out <= 1'b1;
                result_correct   <= 1'b0;
            end
        end
    end

endmodule

// ==== logic/quiz_top.sv ====
`timescale 1ns/100ps

module quiz_top import quiz_pkg::*; #(
    parameter int TICKS_PER_SECOND = 10,
    parameter int TIME_LIMIT       = 20
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  question_index_t total_questions,
    input  player_index_t   total_players,
    input  quiz_category_e  question_category,
    input  op_sel_t         question_op,
    input  operand_t        question_a,
    input  operand_t        question_b,
    input  operand_t        answer_byte,
    input  logic            enter_byte,
    input  logic            confirm,
    input  logic            result_ack,
    output question_index_t question_index,
    output player_index_t   player_index,
    output logic            result_req,
    output player_index_t   result_player,
    output question_index_t result_question,
    output answer_t         result_answer,
    output seconds_t        result_seconds,
    output logic            result_timed_out,
    output logic            result_correct,
    output logic            busy,
    output logic            done
);

    logic    tick;
    logic    tick_restart;
    logic    entry_enable;
    logic    entry_clear;
    answer_t answer_value;
    logic    answer_complete;
    logic    answer_correct;

    second_tick #(
        .TICKS_PER_SECOND (TICKS_PER_SECOND)
    ) i_second_tick (
        .clk          (clk),
        .reset        (reset),
        .tick_restart (tick_restart),
        .tick         (tick)
    );

    answer_entry i_answer_entry (
        .clk               (clk),
        .reset             (reset),
        .entry_enable      (entry_enable),
        .entry_clear       (entry_clear),
        .question_category (question_category),
        .answer_byte       (answer_byte),
        .enter_byte        (enter_byte),
        .confirm           (confirm),
        .answer_value      (answer_value),
        .answer_complete   (answer_complete)
    );

    answer_checker i_answer_checker (
        .question_category (question_category),
        .question_op       (question_op),
        .question_a        (question_a),
        .question_b        (question_b),
        .answer_value      (answer_value),
        .answer_correct    (answer_correct)
    );

    round_control #(
        .TIME_LIMIT (TIME_LIMIT)
    ) i_round_control (
        .clk              (clk),
        .reset            (reset),
        .start            (start),
        .total_questions  (total_questions),
        .total_players    (total_players),
        .tick             (tick),
        .answer_complete  (answer_complete),
        .answer_correct   (answer_correct),
        .answer_value     (answer_value),
        .result_ack       (result_ack),
        .tick_restart     (tick_restart),
        .entry_enable     (entry_enable),
        .entry_clear      (entry_clear),
        .question_index   (question_index),
        .player_index     (player_index),
        .result_req       (result_req),
        .result_player    (result_player),
        .result_question  (result_question),
        .result_answer    (result_answer),
        .result_seconds   (result_seconds),
        .result_timed_out (result_timed_out),
        .result_correct   (result_correct),
        .busy             (busy),
        .done             (done)
    );

endmodule

// ==== verif/clock_gen.sv ====
`timescale 1ns/100ps

module clock_gen #(
    parameter int PERIOD = 8                // ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2);
            clk = ~clk;
        end
    end

endmodule

// ==== verif/quiz_tb.sv ====
`timescale 1ns/100ps

module quiz_tb import quiz_pkg::*; ();

    localparam int TICKS_PER_SECOND = 10;
    localparam int TIME_LIMIT       = 20;
    localparam int CLOCK_PERIOD     = 8;
    localparam int NUM_PLAYERS      = 2;
    localparam int MAX_VECTORS      = 64;
    localparam int LONG_ACK_VECTOR  = 5;        // this attempt holds the ack back

    logic                            clk;
    logic                            reset;
    logic                            start;
    logic [QUESTION_INDEX_WIDTH-1:0] total_questions;
    logic [PLAYER_INDEX_WIDTH-1:0]   total_players;
    quiz_category_e                  question_category;
    logic [1:0]                      question_op;
    logic [OPERAND_WIDTH-1:0]        question_a;
    logic [OPERAND_WIDTH-1:0]        question_b;
    logic [OPERAND_WIDTH-1:0]        answer_byte;
    logic                            enter_byte;
    logic                            confirm;
    logic                            result_ack;
    logic [QUESTION_INDEX_WIDTH-1:0] question_index;
    logic [PLAYER_INDEX_WIDTH-1:0]   player_index;
    logic                            result_req;
    logic [PLAYER_INDEX_WIDTH-1:0]   result_player;
    logic [QUESTION_INDEX_WIDTH-1:0] result_question;
    logic [ANSWER_WIDTH-1:0]         result_answer;
    logic [SECONDS_WIDTH-1:0]        result_seconds;
    logic                            result_timed_out;
    logic                            result_correct;
    logic                            busy;
    logic                            done;

    logic [2:0]  vec_category  [MAX_VECTORS];
    logic [1:0]  vec_op        [MAX_VECTORS];
    logic [7:0]  vec_a         [MAX_VECTORS];
    logic [7:0]  vec_b         [MAX_VECTORS];
    logic [23:0] vec_keys      [MAX_VECTORS];   // first keyed byte in 23..16
    logic        vec_no_answer [MAX_VECTORS];
    logic        vec_correct   [MAX_VECTORS];
    int          vec_count;
    int          question_count;
    logic        vectors_loaded;

    clock_gen #(
        .PERIOD (CLOCK_PERIOD)
    ) i_clock_gen (
        .clk (clk)
    );

    quiz_top #(
        .TICKS_PER_SECOND (TICKS_PER_SECOND),
        .TIME_LIMIT       (TIME_LIMIT)
    ) i_quiz_top (
        .clk               (clk),
        .reset             (reset),
        .start             (start),
        .total_questions   (total_questions),
        .total_players     (total_players),
        .question_category (question_category),
        .question_op       (question_op),
        .question_a        (question_a),
        .question_b        (question_b),
        .answer_byte       (answer_byte),
        .enter_byte        (enter_byte),
        .confirm           (confirm),
        .result_ack        (result_ack),
        .question_index    (question_index),
        .player_index      (player_index),
        .result_req        (result_req),
        .result_player     (result_player),
        .result_question   (result_question),
        .result_answer     (result_answer),
        .result_seconds    (result_seconds),
        .result_timed_out  (result_timed_out),
        .result_correct    (result_correct),
        .busy              (busy),
        .done              (done)
    );

    ////////////////////////////////////////////////////////////////////////////
    // failure reporting and compare
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("Result: FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("error at %0d ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            abort_run("a checked value did not match");
        end
    endtask

    task automatic read_vectors();
        int               fd;
        int               status;
        int               f_cat;
        int               f_op;
        int               f_a;
        int               f_b;
        int               f_k0;
        int               f_k1;
        int               f_k2;
        int               f_mode;
        int               f_ok;
        logic [8*128-1:0] line;
        fd = $fopen("verif/quiz_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open verif/quiz_vectors.txt");
        end
        vec_count = 0;
        while ($fgets(line, fd) > 0) begin
            status = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                             f_cat, f_op, f_a, f_b, f_k0, f_k1, f_k2, f_mode, f_ok);
            if (status == 9 && vec_count < MAX_VECTORS) begin   // comment lines give 0
                vec_category[vec_count]  = 3'(f_cat);
                vec_op[vec_count]        = 2'(f_op);
                vec_a[vec_count]         = 8'(f_a);
                vec_b[vec_count]         = 8'(f_b);
                vec_keys[vec_count]      = {8'(f_k0), 8'(f_k1), 8'(f_k2)};
                vec_no_answer[vec_count] = (f_mode != 0);
                vec_correct[vec_count]   = (f_ok != 0);
                vec_count = vec_count + 1;
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // player actions
    ////////////////////////////////////////////////////////////////////////////

    task automatic key_byte(input logic [7:0] value, input logic last);
        int idle;
        idle = $urandom_range(0, 3);
        repeat (idle) begin
            @(posedge clk);
        end
        @(posedge clk);
        answer_byte <= value;
        enter_byte  <= !last;
        confirm     <= last;
        @(negedge clk);
        check(32'(result_req), 0, "request before the key is sampled");
        @(posedge clk);
        enter_byte <= 1'b0;
        confirm    <= 1'b0;
        @(negedge clk);
        check(32'(result_req), 32'(last), "request one cycle after confirm");
    endtask

    task automatic acknowledge(input int delay);
        logic [QUESTION_INDEX_WIDTH-1:0] held_question;
        logic [ANSWER_WIDTH-1:0]         held_answer;
        held_question = result_question;
        held_answer   = result_answer;
        for (int i = 0; i < delay; i++) begin
            @(posedge clk);
            answer_byte <= 8'(i);                   // keys pressed while the record waits
            enter_byte  <= ((i % 3) != 2);
            confirm     <= ((i % 3) == 2);
            @(negedge clk);
            check(32'(result_req), 1, "request held while ack is late");
            check(32'(result_question), 32'(held_question), "record stable during ack delay");
            check(32'(result_answer), 32'(held_answer), "answer stable during ack delay");
        end
        @(posedge clk);
        enter_byte <= 1'b0;
        confirm    <= 1'b0;
        result_ack <= 1'b1;
        @(posedge clk);                         // DUT samples ack here
        @(negedge clk);
        check(32'(result_req), 0, "request dropped after ack");
        @(posedge clk);
        result_ack <= 1'b0;
        @(negedge clk);
        check(32'(result_req), 0, "no new request before ack low");
    endtask

    task automatic run_attempt(input int k);
        logic        multi_byte;
        logic [23:0] keyed;
        int          waited;
        int          delay;
        multi_byte = (vec_category[k] == 3'd1) || (vec_category[k] == 3'd2);
        keyed      = multi_byte ? vec_keys[k] : {vec_keys[k][23:16], 16'h0000};
        @(posedge clk);
        question_category <= quiz_category_e'(vec_category[k]);
        question_op       <= vec_op[k];
        question_a        <= vec_a[k];
        question_b        <= vec_b[k];
        if (k == 0) begin
            start <= 1'b1;
        end
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check(32'(busy), 1, "busy while a question is open");
        check(32'(question_index), 32'(k % question_count), "question index");
        check(32'(player_index), 32'(k / question_count), "player index");
        check(32'(result_req), 0, "request before any answer");
        if (vec_no_answer[k]) begin
            waited = 0;
            while (result_req !== 1'b1) begin
                if (waited > (TIME_LIMIT + 1) * TICKS_PER_SECOND) begin
                    abort_run("no record came after the time limit ran out");
                end
                @(negedge clk);
                waited = waited + 1;
            end
            check(32'(waited >= (TIME_LIMIT - 1) * TICKS_PER_SECOND), 1, "timeout too early");
            check(32'(result_timed_out), 1, "timed-out flag");
            check(32'(result_seconds), TIME_LIMIT, "seconds on timeout");
            check(32'(result_correct), 0, "correct flag on timeout");
            check(32'(result_answer), 0, "answer on timeout");
        end else begin
            if (multi_byte) begin
                key_byte(vec_keys[k][23:16], 1'b0);
                key_byte(vec_keys[k][15:8], 1'b0);
                key_byte(vec_keys[k][7:0], 1'b1);
            end else begin
                key_byte(vec_keys[k][23:16], 1'b1);
            end
            check(32'(result_timed_out), 0, "timed-out flag");
            check(32'(result_seconds <= 5'(TIME_LIMIT)), 1, "seconds within limit");
            check(32'(result_correct), 32'(vec_correct[k]), "correct flag");
            check(32'(result_answer), 32'(keyed), "answer");
        end
        check(32'(result_player), 32'(k / question_count), "record player");
        check(32'(result_question), 32'(k % question_count), "record question");
        if (k == LONG_ACK_VECTOR) begin
            delay = 120 + $urandom_range(0, 15);
        end else begin
            delay = $urandom_range(0, 5);
        end
        acknowledge(delay);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin : watchdog
        longint budget;
        wait (vectors_loaded === 1'b1);
        budget = longint'(vec_count) * (TIME_LIMIT + 2) * TICKS_PER_SECOND * CLOCK_PERIOD;
        #(budget + 2000);
        abort_run("watchdog expired before the test finished");
    end

    initial begin
        reset             <= 1'b1;
        start             <= 1'b0;
        total_questions   <= '0;
        total_players     <= '0;
        question_category <= CAT_CONVERT;
        question_op       <= 2'd0;
        question_a        <= 8'h00;
        question_b        <= 8'h00;
        answer_byte       <= 8'h00;
        enter_byte        <= 1'b0;
        confirm           <= 1'b0;
        result_ack        <= 1'b0;
        void'($urandom(55363));
        read_vectors();
        if (vec_count == 0 || (vec_count % NUM_PLAYERS) != 0) begin
            abort_run("vector file has no vectors or an uneven count per player");
        end
        question_count = vec_count / NUM_PLAYERS;
        vectors_loaded = 1'b1;
        repeat (5) begin
            @(posedge clk);
        end
        reset           <= 1'b0;
        total_questions <= QUESTION_INDEX_WIDTH'(question_count);
        total_players   <= PLAYER_INDEX_WIDTH'(NUM_PLAYERS);
        repeat (3) begin
            @(negedge clk);
            check(32'(result_req), 0, "request after reset");
            check(32'(busy), 0, "busy after reset");
            check(32'(done), 0, "done after reset");
        end
        for (int k = 0; k < vec_count; k++) begin
            run_attempt(k);
        end
        @(posedge clk);                         // DUT sees ack low, round ends
        repeat (4) begin
            @(negedge clk);
            check(32'(done), 1, "done after the last record");
            check(32'(busy), 0, "busy after the last record");
            check(32'(result_req), 0, "extra record after the round");
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== verif/quiz_vectors.txt ====
# category op a b key0 key1 key2 no_answer correct, all hex
# first half is player 0, second half player 1, same question slots
1 0 a7 00 02 04 07 0 1
1 1 c8 00 02 00 00 0 1
1 2 3e 00 00 03 0e 0 1
1 3 55 00 00 00 00 0 1
2 0 14 e2 80 01 00 0 1
2 1 50 0d 00 06 07 0 1
3 0 35 02 d4 00 00 0 1
3 1 90 0b f2 00 00 0 1
4 0 ca 5f 4a 00 00 0 1
5 0 00 12 00 00 00 0 1
4 1 0f f0 00 00 00 1 0
0 0 12 34 00 00 00 0 0
2 2 33 44 00 00 00 0 1
2 3 33 44 00 00 01 0 0
3 2 81 01 02 00 00 0 1
3 3 90 03 f2 00 00 0 0
4 1 a0 05 a5 00 00 0 1
4 2 3c 00 c3 00 00 0 1
4 3 ff 0f 0f 00 00 0 0
5 1 00 00 ff 00 00 0 0
5 2 00 77 ff 00 00 0 1
5 3 01 80 00 00 00 0 1
6 1 00 00 ff 00 00 0 0
1 0 3f 00 00 07 06 0 0

// ==== project.f ====
logic/quiz_pkg.sv
logic/second_tick.sv
logic/answer_entry.sv
logic/answer_checker.sv
logic/round_control.sv
logic/quiz_top.sv
verif/clock_gen.sv
verif/quiz_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/100ps -f project.f \
		--top-module quiz_tb -Mdir obj_dir -o quiz_sim
	./obj_dir/quiz_sim

clean:
	rm -rf obj_dir
